/* include/mam_cfg.svh */
// Bridge configuration: word, address and flit widths, response packet length
`ifndef MAM_CFG_SVH
`define MAM_CFG_SVH

// Memory word, a multiple of the flit width
`define MAM_DATA_WIDTH 32

// Sent as 16-bit flits, most significant first
`define MAM_ADDR_WIDTH 32

`define MAM_FLIT_WIDTH 16

// Response packet size in flits, 3 header flits included
`define MAM_MAX_PKT_LEN 8

`endif

/* hdl/mam_pkg.sv */
// Bridge types: flit, word, address, strobe and beat count, FSM state enums
`include "mam_cfg.svh"

package mam_pkg;

   typedef logic [`MAM_FLIT_WIDTH-1:0] flit_t;
   typedef logic [`MAM_DATA_WIDTH-1:0] word_t;
   typedef logic [`MAM_ADDR_WIDTH-1:0] addr_t;
   typedef logic [`MAM_DATA_WIDTH/8-1:0] strb_t;
   typedef logic [12:0] beats_t;      // Burst length in words

   // Request parser
   typedef enum logic [3:0] {
      PS_IDLE,       // Finish off the previous input packet
      PS_DEST,
      PS_SRC,
      PS_FLAGS,
      PS_HEADER,
      PS_ADDR,
      PS_REQUEST,
      PS_FORWARD,    // Write data goes on to the assembler
      PS_WAIT_DONE
   } parse_state_t;

   // Write assembler
   typedef enum logic [2:0] {
      WS_IDLE,
      WS_CONT,       // Dropping the header of a continuation packet
      WS_COLLECT,
      WS_WRITE,
      WS_WAIT        // Sync write, waiting for write_complete
   } wr_state_t;

   // Read packer
   typedef enum logic [1:0] {
      RS_IDLE,
      RS_HEADER,
      RS_DATA,
      RS_EVENT
   } rd_state_t;

endpackage

/* hdl/mam_cmd_parser.sv */
// Request parser: header decode, request registers, memory request and write data forwarding
`timescale 1ns/1ps
`include "mam_cfg.svh"

module mam_cmd_parser (
   input  logic            clk,
   input  logic            rst,
   input  logic            debug_in_valid,
   input  mam_pkg::flit_t  debug_in_data,
   input  logic            debug_in_last,
   output logic            debug_in_ready,
   output logic            req_valid,
   output logic            req_we,
   output logic            req_burst,
   output logic            req_sync,
   output mam_pkg::addr_t  req_addr,
   output mam_pkg::beats_t req_beats,
   input  logic            req_ready,
   output mam_pkg::strb_t  write_strb,
   output logic            fwd_valid,
   output mam_pkg::flit_t  fwd_data,
   output logic            fwd_last,
   input  logic            fwd_ready,
   output mam_pkg::flit_t  req_src,
   output logic            wr_start,
   output logic            rd_start,
   input  logic            wr_done,
   input  logic            rd_done
);

   localparam int ADDR_FLITS = `MAM_ADDR_WIDTH / `MAM_FLIT_WIDTH;
   localparam int STRB_W = `MAM_DATA_WIDTH / 8;

   mam_pkg::parse_state_t state;
   logic [1:0] addr_cnt;       // Address flits taken so far
   logic       in_pkt;         // Last flit of the input packet not seen yet
   logic       accept;

   always_comb begin
      case (state)
         mam_pkg::PS_IDLE:      debug_in_ready = in_pkt;   // Drain leftover flits only
         mam_pkg::PS_REQUEST:   debug_in_ready = 1'b0;
         mam_pkg::PS_WAIT_DONE: debug_in_ready = 1'b0;
         mam_pkg::PS_FORWARD:   debug_in_ready = fwd_ready;
         default:               debug_in_ready = 1'b1;
      endcase
   end

   assign accept = debug_in_valid && debug_in_ready;
   assign req_valid = state == mam_pkg::PS_REQUEST;
   assign wr_start = req_valid && req_ready && req_we;
   assign rd_start = req_valid && req_ready && !req_we;

   assign fwd_valid = (state == mam_pkg::PS_FORWARD) && debug_in_valid;
   assign fwd_data = debug_in_data;
   // Before forwarding starts, tells the assembler the address flit closed the packet
   assign fwd_last = (state == mam_pkg::PS_FORWARD) ? debug_in_last : !in_pkt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mam_pkg::PS_DEST;
         in_pkt <= 1'b0;
         addr_cnt <= '0;
      end else begin
         if (accept) begin
            in_pkt <= !debug_in_last;
         end
         case (state)
            mam_pkg::PS_IDLE: begin
               if (!in_pkt || (accept && debug_in_last)) begin
                  state <= mam_pkg::PS_DEST;
               end
            end
            mam_pkg::PS_DEST: begin
               if (accept && !debug_in_last) begin   // A lone flit is no request
                  state <= mam_pkg::PS_SRC;
               end
            end
            mam_pkg::PS_SRC: begin
               if (accept) begin
                  state <= debug_in_last ? mam_pkg::PS_DEST : mam_pkg::PS_FLAGS;
               end
            end
            mam_pkg::PS_FLAGS: begin
               if (accept) begin
                  state <= debug_in_last ? mam_pkg::PS_DEST : mam_pkg::PS_HEADER;
               end
            end
            mam_pkg::PS_HEADER: begin
               addr_cnt <= '0;
               if (accept) begin
                  state <= debug_in_last ? mam_pkg::PS_DEST : mam_pkg::PS_ADDR;
               end
            end
            mam_pkg::PS_ADDR: begin
               if (accept) begin
                  addr_cnt <= addr_cnt + 1'b1;
                  if (addr_cnt == 2'(ADDR_FLITS - 1)) begin
                     state <= mam_pkg::PS_REQUEST;
                  end else if (debug_in_last) begin
                     state <= mam_pkg::PS_DEST;      // Address cut short, drop it
                  end
               end
            end
            mam_pkg::PS_REQUEST: begin
               if (req_ready) begin
                  state <= req_we ? mam_pkg::PS_FORWARD : mam_pkg::PS_WAIT_DONE;
               end
            end
            default: begin
               if (wr_done || rd_done) begin
                  state <= mam_pkg::PS_IDLE;
               end
            end
         endcase
      end
   end

   // Request fields
   always_ff @(posedge clk) begin
      if (accept) begin
         case (state)
            mam_pkg::PS_SRC: req_src <= debug_in_data;
            mam_pkg::PS_HEADER: begin
               req_we <= debug_in_data[15];
               req_burst <= debug_in_data[14];
               req_sync <= debug_in_data[13];
               req_beats <= debug_in_data[14] ? debug_in_data[12:0] : 13'd1;
               write_strb <= debug_in_data[STRB_W-1:0];
            end
            mam_pkg::PS_ADDR: begin
               req_addr <= {req_addr[`MAM_ADDR_WIDTH-`MAM_FLIT_WIDTH-1:0], debug_in_data};
            end
            default: ;
         endcase
      end
   end

endmodule

/* hdl/mam_write_assembler.sv */
// Write assembler: flits to words, continuation header removal, write port, sync completion wait
`timescale 1ns/1ps
`include "mam_cfg.svh"

module mam_write_assembler (
   input  logic            clk,
   input  logic            rst,
   input  logic            fwd_valid,
   input  mam_pkg::flit_t  fwd_data,
   input  logic            fwd_last,
   output logic            fwd_ready,
   input  logic            wr_start,
   input  mam_pkg::beats_t req_beats,
   input  logic            req_sync,
   output logic            write_valid,
   output mam_pkg::word_t  write_data,
   input  logic            write_ready,
   input  logic            write_complete,
   output logic            sync_start,
   output logic            wr_done
);

   localparam int HALVES = `MAM_DATA_WIDTH / `MAM_FLIT_WIDTH;
   localparam int HW = $clog2(HALVES);

   mam_pkg::wr_state_t state;
   mam_pkg::beats_t    beats_left;
   mam_pkg::word_t     word_q;
   logic [HW-1:0]      half_cnt;
   logic [1:0]         hdr_cnt;
   logic               pkt_end;    // Held word closed its input packet
   logic               take;
   logic               final_beat;

   assign fwd_ready = (state == mam_pkg::WS_CONT) || (state == mam_pkg::WS_COLLECT);
   assign take = fwd_valid && fwd_ready;
   assign write_valid = state == mam_pkg::WS_WRITE;
   assign write_data = word_q;
   assign final_beat = beats_left == 13'd1;
   assign wr_done = write_valid && write_ready && final_beat && !req_sync;
   assign sync_start = (state == mam_pkg::WS_WAIT) && write_complete;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mam_pkg::WS_IDLE;
         half_cnt <= '0;
         hdr_cnt <= '0;
      end else begin
         case (state)
            mam_pkg::WS_IDLE: begin
               half_cnt <= '0;
               hdr_cnt <= '0;
               if (wr_start) begin
                  state <= fwd_last ? mam_pkg::WS_CONT : mam_pkg::WS_COLLECT;
               end
            end
            mam_pkg::WS_CONT: begin
               if (take) begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt == 2'd2) begin
                     hdr_cnt <= '0;
                     state <= mam_pkg::WS_COLLECT;
                  end
               end
            end
            mam_pkg::WS_COLLECT: begin
               if (take) begin
                  if (half_cnt == HW'(HALVES - 1)) begin
                     half_cnt <= '0;
                     state <= mam_pkg::WS_WRITE;
                  end else begin
                     half_cnt <= half_cnt + 1'b1;
                     if (fwd_last) begin
                        state <= mam_pkg::WS_CONT;     // Word goes on in the next packet
                     end
                  end
               end
            end
            mam_pkg::WS_WRITE: begin
               if (write_ready) begin
                  if (final_beat) begin
                     state <= req_sync ? mam_pkg::WS_WAIT : mam_pkg::WS_IDLE;
                  end else begin
                     state <= pkt_end ? mam_pkg::WS_CONT : mam_pkg::WS_COLLECT;
                  end
               end
            end
            default: begin
               if (write_complete) begin
                  state <= mam_pkg::WS_IDLE;
               end
            end
         endcase
      end
   end

   // Upper half arrives first and shifts up
   always_ff @(posedge clk) begin
      if (take && state == mam_pkg::WS_COLLECT) begin
         word_q <= {word_q[`MAM_DATA_WIDTH-`MAM_FLIT_WIDTH-1:0], fwd_data};
         pkt_end <= fwd_last;
      end
      if (wr_start) begin
         beats_left <= req_beats;
      end else if (write_valid && write_ready) begin
         beats_left <= beats_left - 1'b1;
      end
   end

endmodule

/* hdl/mam_read_packer.sv */
// Read packer: read words to response packets, sync event packet
`timescale 1ns/1ps
`include "mam_cfg.svh"

module mam_read_packer (
   input  logic            clk,
   input  logic            rst,
   input  mam_pkg::flit_t  id,
   input  mam_pkg::flit_t  req_src,
   input  mam_pkg::beats_t req_beats,
   input  logic            rd_start,
   input  logic            sync_start,
   input  logic            read_valid,
   input  mam_pkg::word_t  read_data,
   output logic            read_ready,
   output logic            debug_out_valid,
   output mam_pkg::flit_t  debug_out_data,
   output logic            debug_out_last,
   input  logic            debug_out_ready,
   output logic            rd_done
);

   localparam int FLIT = `MAM_FLIT_WIDTH;
   localparam int HALVES = `MAM_DATA_WIDTH / FLIT;
   localparam int HW = $clog2(HALVES);
   localparam int PAYLOAD = `MAM_MAX_PKT_LEN - 3;   // Data flits per packet
   localparam int PW = $clog2(PAYLOAD);

   mam_pkg::rd_state_t state;
   mam_pkg::beats_t    beats_left;
   logic [HW-1:0]      half_cnt;
   logic [PW-1:0]      flit_cnt;
   logic [1:0]         hdr_cnt;
   logic               send;
   logic               last_half;
   logic               pkt_full;
   logic               final_flit;

   assign send = debug_out_valid && debug_out_ready;
   assign last_half = half_cnt == HW'(HALVES - 1);
   assign pkt_full = flit_cnt == PW'(PAYLOAD - 1);
   assign final_flit = last_half && (beats_left == 13'd1);
   assign read_ready = (state == mam_pkg::RS_DATA) && send && last_half;
   assign rd_done = send && (((state == mam_pkg::RS_EVENT) && (hdr_cnt == 2'd2)) ||
                             ((state == mam_pkg::RS_DATA) && final_flit));

   always_comb begin
      debug_out_valid = 1'b0;
      debug_out_last = 1'b0;
      debug_out_data = read_data[(HALVES - 1 - half_cnt) * FLIT +: FLIT];
      case (state)
         mam_pkg::RS_HEADER, mam_pkg::RS_EVENT: begin
            debug_out_valid = 1'b1;
            case (hdr_cnt)
               2'd0:    debug_out_data = req_src;         // Back to the requester
               2'd1:    debug_out_data = id;
               default: debug_out_data = {2'b10, 14'd0};  // Event type, no subtype
            endcase
            debug_out_last = (state == mam_pkg::RS_EVENT) && (hdr_cnt == 2'd2);
         end
         mam_pkg::RS_DATA: begin
            debug_out_valid = read_valid;
            debug_out_last = pkt_full || final_flit;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mam_pkg::RS_IDLE;
         hdr_cnt <= '0;
         half_cnt <= '0;
         flit_cnt <= '0;
      end else begin
         case (state)
            mam_pkg::RS_IDLE: begin
               if (rd_start) begin
                  state <= mam_pkg::RS_HEADER;
               end else if (sync_start) begin
                  state <= mam_pkg::RS_EVENT;
               end
            end
            mam_pkg::RS_HEADER, mam_pkg::RS_EVENT: begin
               if (send) begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt == 2'd2) begin
                     hdr_cnt <= '0;
                     state <= (state == mam_pkg::RS_HEADER) ? mam_pkg::RS_DATA
                                                            : mam_pkg::RS_IDLE;
                  end
               end
            end
            default: begin
               if (send) begin
                  half_cnt <= last_half ? '0 : half_cnt + 1'b1;
                  flit_cnt <= (pkt_full || final_flit) ? '0 : flit_cnt + 1'b1;
                  if (final_flit) begin
                     state <= mam_pkg::RS_IDLE;
                  end else if (pkt_full) begin
                     state <= mam_pkg::RS_HEADER;   // Rest goes out in a new packet
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_start) begin
         beats_left <= req_beats;
      end else if (read_ready) begin
         beats_left <= beats_left - 1'b1;
      end
   end

endmodule

/* hdl/mam_top.sv */
// Memory access bridge top level: parser, write assembler and read packer
`timescale 1ns/1ps

module mam_top (
   input  logic            clk,
   input  logic            rst,
   input  mam_pkg::flit_t  id,
   input  logic            debug_in_valid,
   input  mam_pkg::flit_t  debug_in_data,
   input  logic            debug_in_last,
   output logic            debug_in_ready,
   output logic            debug_out_valid,
   output mam_pkg::flit_t  debug_out_data,
   output logic            debug_out_last,
   input  logic            debug_out_ready,
   output logic            req_valid,
   output logic            req_we,
   output logic            req_burst,
   output logic            req_sync,
   output mam_pkg::addr_t  req_addr,
   output mam_pkg::beats_t req_beats,
   input  logic            req_ready,
   output logic            write_valid,
   output mam_pkg::word_t  write_data,
   output mam_pkg::strb_t  write_strb,
   input  logic            write_ready,
   input  logic            write_complete,
   input  logic            read_valid,
   input  mam_pkg::word_t  read_data,
   output logic            read_ready
);

   logic           fwd_valid;
   mam_pkg::flit_t fwd_data;
   logic           fwd_last;
   logic           fwd_ready;
   mam_pkg::flit_t req_src;
   logic           wr_start;
   logic           rd_start;
   logic           wr_done;
   logic           rd_done;
   logic           sync_start;

   mam_cmd_parser i_cmd_parser (
      .clk, .rst,
      .debug_in_valid, .debug_in_data, .debug_in_last, .debug_in_ready,
      .req_valid, .req_we, .req_burst, .req_sync, .req_addr, .req_beats, .req_ready,
      .write_strb,
      .fwd_valid, .fwd_data, .fwd_last, .fwd_ready,
      .req_src, .wr_start, .rd_start, .wr_done, .rd_done
   );

   mam_write_assembler i_write_assembler (
      .clk, .rst,
      .fwd_valid, .fwd_data, .fwd_last, .fwd_ready,
      .wr_start, .req_beats, .req_sync,
      .write_valid, .write_data, .write_ready, .write_complete,
      .sync_start, .wr_done
   );

   // Also sends the event packet that closes a sync write
   mam_read_packer i_read_packer (
      .clk, .rst,
      .id, .req_src, .req_beats, .rd_start, .sync_start,
      .read_valid, .read_data, .read_ready,
      .debug_out_valid, .debug_out_data, .debug_out_last, .debug_out_ready,
      .rd_done
   );

endmodule

/* sim/mam_props.sv */
// Handshake properties for the bridge top level, bound to mam_top
`timescale 1ns/1ps

module mam_props (
   input logic            clk,
   input logic            rst,
   input logic            debug_in_valid,
   input mam_pkg::flit_t  debug_in_data,
   input logic            debug_in_last,
   input logic            debug_in_ready,
   input logic            debug_out_valid,
   input mam_pkg::flit_t  debug_out_data,
   input logic            debug_out_last,
   input logic            debug_out_ready,
   input logic            req_valid,
   input mam_pkg::addr_t  req_addr,
   input logic            req_we,
   input mam_pkg::beats_t req_beats,
   input logic            req_ready,
   input logic            write_valid,
   input mam_pkg::word_t  write_data,
   input logic            write_ready,
   input logic            read_valid,
   input mam_pkg::word_t  read_data,
   input logic            read_ready
);

   // A stalled channel keeps valid and its payload
   in_stable: assert property (@(posedge clk) disable iff (rst)
      debug_in_valid && !debug_in_ready |=>
         debug_in_valid && $stable(debug_in_data) && $stable(debug_in_last))
      else $error("debug_in changed while stalled");

   out_stable: assert property (@(posedge clk) disable iff (rst)
      debug_out_valid && !debug_out_ready |=>
         debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
      else $error("debug_out changed while stalled");

   req_stable: assert property (@(posedge clk) disable iff (rst)
      req_valid && !req_ready |=>
         req_valid && $stable(req_addr) && $stable(req_we) && $stable(req_beats))
      else $error("Memory request changed while stalled");

   write_stable: assert property (@(posedge clk) disable iff (rst)
      write_valid && !write_ready |=> write_valid && $stable(write_data))
      else $error("Write data changed while stalled");

   read_stable: assert property (@(posedge clk) disable iff (rst)
      read_valid && !read_ready |=> read_valid && $stable(read_data))
      else $error("Read data changed while stalled");

   req_write_excl: assert property (@(posedge clk) disable iff (rst)
      !(req_valid && write_valid))
      else $error("Request and write valid at once");

endmodule

bind mam_top mam_props i_props (
   .clk, .rst,
   .debug_in_valid, .debug_in_data, .debug_in_last, .debug_in_ready,
   .debug_out_valid, .debug_out_data, .debug_out_last, .debug_out_ready,
   .req_valid, .req_addr, .req_we, .req_beats, .req_ready,
   .write_valid, .write_data, .write_ready,
   .read_valid, .read_data, .read_ready
);

/* sim/mam_tb.sv */
// Bridge testbench: clock, reset, random request packets, memory and response models, watchdog
`timescale 1ns/1ps
`include "mam_cfg.svh"

module mam_tb;

   localparam int NUM_REQ = 24;
   localparam int REQ_NS = 3000;          // Upper bound for one request
   localparam int PAYLOAD = `MAM_MAX_PKT_LEN - 3;

   logic clk = 1'b0;
   logic rst;
   mam_pkg::flit_t id;
   logic debug_in_valid, debug_in_last, debug_in_ready;
   mam_pkg::flit_t debug_in_data;
   logic debug_out_valid, debug_out_last, debug_out_ready;
   mam_pkg::flit_t debug_out_data;
   logic req_valid, req_we, req_burst, req_sync, req_ready;
   mam_pkg::addr_t req_addr;
   mam_pkg::beats_t req_beats;
   logic write_valid, write_ready, write_complete;
   mam_pkg::word_t write_data;
   logic [3:0] write_strb;
   logic read_valid, read_ready;
   mam_pkg::word_t read_data;

   mam_top i_mam_top (.*);

   always #2 clk = ~clk;

   // Model state
   mam_pkg::word_t mem [logic [31:0]];
   logic [47:0]    exp_req[$];            // we, burst, sync, beats, addr
   mam_pkg::word_t exp_wr_data[$];
   logic [3:0]     exp_wr_strb[$];
   mam_pkg::flit_t exp_out_data[$];
   bit             exp_out_last[$];
   bit             exp_out_cmpl[$];       // Flit may only follow write_complete
   logic [31:0]    wr_addr, rd_addr;
   int             wr_left, rd_left, cmpl_delay;
   bit             wr_single, wr_sync, rd_taken, cmpl_seen;
   int             val_errors, other_errors;

   function automatic mam_pkg::word_t mem_read(input logic [31:0] a);
      if (mem.exists(a)) return mem[a];
      return (a * 32'h9E37_79B1) ^ 32'hA5A5_0F0F;   // Fill for untouched words
   endfunction

   function automatic mam_pkg::word_t merge_word(input mam_pkg::word_t old_w,
                                                 input mam_pkg::word_t new_w,
                                                 input logic [3:0] strb);
      mam_pkg::word_t r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) r[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return r;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] got_v);
      assert (got_v === exp_v) else begin
         val_errors++;
         $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_v, got_v);
      end
   endtask

   task automatic push_out(input mam_pkg::flit_t d, input bit l, input bit c);
      exp_out_data.push_back(d);
      exp_out_last.push_back(l);
      exp_out_cmpl.push_back(c);
   endtask

   // Called on a falling edge, returns on a falling edge
   task automatic send_flit(input mam_pkg::flit_t d, input bit l);
      if ($urandom % 4 == 0) begin
         debug_in_valid = 1'b0;
         @(negedge clk);
      end
      debug_in_valid = 1'b1;
      debug_in_data = d;
      debug_in_last = l;
      @(posedge clk);
      while (!debug_in_ready) @(posedge clk);
      @(negedge clk);
      debug_in_valid = 1'b0;
   endtask

   task automatic send_cont_header();
      repeat (3) send_flit(16'($urandom), 1'b0);
   endtask

   task automatic send_request(input bit we, input bit burst, input bit sync,
                               input int beats, input logic [31:0] addr,
                               input logic [3:0] strb);
      mam_pkg::flit_t src;
      mam_pkg::word_t words[$];
      mam_pkg::word_t w;
      bit split_addr, split, fin;
      int nflit;
      src = 16'($urandom);
      exp_req.push_back({we, burst, sync, 13'(beats), addr});
      for (int i = 0; i < beats; i++) begin
         words.push_back(32'($urandom));
         if (we) begin
            exp_wr_data.push_back(words[i]);
            exp_wr_strb.push_back(strb);
         end
      end
      if (!we) begin                      // Responses from the model memory
         nflit = 0;
         for (int k = 0; k < 2 * beats; k++) begin
            if (nflit == 0) begin
               push_out(src, 1'b0, 1'b0);
               push_out(id, 1'b0, 1'b0);
               push_out(16'h8000, 1'b0, 1'b0);
            end
            fin = (k == 2 * beats - 1) || (nflit == PAYLOAD - 1);
            w = mem_read(addr + 32'(4 * (k / 2)));
            push_out(k[0] ? w[15:0] : w[31:16], fin, 1'b0);
            nflit = fin ? 0 : nflit + 1;
         end
      end else if (sync) begin
         push_out(src, 1'b0, 1'b1);
         push_out(id, 1'b0, 1'b1);
         push_out(16'h8000, 1'b1, 1'b1);
      end
      split_addr = we && burst && ($urandom % 3 == 0);
      send_flit(16'($urandom), 1'b0);
      send_flit(src, 1'b0);
      send_flit(16'($urandom), 1'b0);
      send_flit({we, burst, sync, burst ? 13'(beats) : {9'd0, strb}}, 1'b0);
      send_flit(addr[31:16], 1'b0);
      send_flit(addr[15:0], !we || split_addr);
      if (split_addr) send_cont_header();
      if (we) begin
         for (int k = 0; k < 2 * beats; k++) begin
            fin = k == 2 * beats - 1;
            split = !fin && burst && ($urandom % 5 == 0);
            send_flit(k[0] ? words[k / 2][15:0] : words[k / 2][31:16], fin || split);
            if (split) send_cont_header();
         end
      end
      // Wait until every expected beat and flit has shown up
      while (exp_req.size() + exp_wr_data.size() + exp_out_data.size() != 0) begin
         @(negedge clk);
      end
   endtask

   // Memory and output side, driven on the falling edge
   always @(negedge clk) begin
      req_ready = $urandom % 3 != 0;
      write_ready = $urandom % 3 != 0;
      debug_out_ready = $urandom % 4 != 0;
      write_complete = 1'b0;
      if (cmpl_delay > 0) begin
         cmpl_delay--;
         if (cmpl_delay == 0) begin
            write_complete = 1'b1;
            cmpl_seen = 1'b1;
         end
      end
      if (rd_taken) begin
         read_valid = 1'b0;
         rd_taken = 1'b0;
      end
      if (!read_valid && rd_left > 0 && $urandom % 3 != 0) begin
         read_valid = 1'b1;
         read_data = mem_read(rd_addr);
      end
   end

   // Handshake monitor, sampled on the rising edge
   always @(posedge clk) begin : monitor
      logic [47:0] e;
      mam_pkg::word_t d;
      logic [3:0] s;
      if (!rst) begin
         if (req_valid && req_ready) begin
            if (exp_req.size() == 0) begin
               other_errors++;
               $display("Unexpected memory request at %0t ns", $time);
            end else begin
               e = exp_req.pop_front();
               check_val("req_addr", e[31:0], req_addr);
               check_val("req_beats", 32'(e[44:32]), 32'(req_beats));
               check_val("req_we", 32'(e[47]), 32'(req_we));
               check_val("req_burst", 32'(e[46]), 32'(req_burst));
               check_val("req_sync", 32'(e[45]), 32'(req_sync));
            end
            if (req_we) begin
               wr_addr = req_addr;
               wr_left = int'(req_beats);
               wr_single = !req_burst;
               wr_sync = req_sync;
            end else begin
               rd_addr = req_addr;
               rd_left = int'(req_beats);
            end
         end
         if (write_valid && write_ready) begin
            if (exp_wr_data.size() == 0) begin
               other_errors++;
               $display("Unexpected write beat at %0t ns", $time);
            end else begin
               d = exp_wr_data.pop_front();
               s = exp_wr_strb.pop_front();
               check_val("write_data", d, write_data);
               if (wr_single) check_val("write_strb", 32'(s), 32'(write_strb));
               mem[wr_addr] = wr_single ? merge_word(mem_read(wr_addr), d, s) : d;
            end
            wr_addr += 4;
            wr_left--;
            if (wr_left == 0 && wr_sync) cmpl_delay = 1 + int'($urandom % 8);
         end
         if (read_valid && read_ready) begin
            rd_taken = 1'b1;
            rd_left--;
            rd_addr += 4;
         end
         if (debug_out_valid && debug_out_ready) begin
            if (exp_out_data.size() == 0) begin
               other_errors++;
               $display("Unexpected response flit at %0t ns", $time);
            end else begin
               check_val("debug_out_data", 32'(exp_out_data.pop_front()), 32'(debug_out_data));
               check_val("debug_out_last", 32'(exp_out_last.pop_front()), 32'(debug_out_last));
               if (exp_out_cmpl.pop_front()) begin
                  assert (cmpl_seen) else begin
                     other_errors++;
                     $display("Event packet sent before write_complete at %0t ns", $time);
                  end
               end
            end
         end
      end
   end

   initial begin
      logic [31:0] burst_addr;
      int burst_beats, kind;
      void'($urandom(32'h982));
      id = 16'($urandom);
      rst = 1'b1;
      {debug_in_valid, debug_in_last, debug_in_data} = '0;
      {debug_out_ready, req_ready, write_ready, write_complete} = '0;
      {read_valid, read_data} = '0;
      {rd_left, wr_left, cmpl_delay, rd_taken, cmpl_seen} = '0;
      {val_errors, other_errors} = '0;
      burst_addr = 32'h100;
      burst_beats = 4;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(posedge clk);
      check_val("req_valid", 0, 32'(req_valid));
      check_val("write_valid", 0, 32'(write_valid));
      check_val("read_ready", 0, 32'(read_ready));
      check_val("debug_out_valid", 0, 32'(debug_out_valid));
      check_val("debug_in_ready", 1, 32'(debug_in_ready));
      @(negedge clk);
      for (int i = 0; i < NUM_REQ; i++) begin
         kind = (i < 4) ? i : int'($urandom % 4);
         case (kind)
            0: send_request(1'b1, 1'b0, 1'b0, 1, 32'($urandom) & 32'hFFFF_FFFC, 4'($urandom));
            1: begin
               burst_addr = 32'($urandom) & 32'h0000_FFFC;
               burst_beats = 1 + int'($urandom % 12);
               send_request(1'b1, 1'b1, 1'b0, burst_beats, burst_addr, 4'hF);
            end
            2: send_request(1'b0, 1'b1, 1'b0, burst_beats, burst_addr, 4'hF);
            default: begin
               cmpl_seen = 1'b0;
               send_request(1'b1, 1'b0, 1'b1, 1, burst_addr, 4'($urandom));
            end
         endcase
      end
      repeat (10) @(negedge clk);
      $display("Errors: %0d value mismatches, %0d other", val_errors, other_errors);
      if (val_errors + other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(NUM_REQ * REQ_NS + 100);
      $display("Timeout: the run did not finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

/* sources.f */
+incdir+include
hdl/mam_pkg.sv
hdl/mam_cmd_parser.sv
hdl/mam_write_assembler.sv
hdl/mam_read_packer.sv
hdl/mam_top.sv
sim/mam_props.sv
sim/mam_tb.sv

/* Makefile */
# Verilator simulation of the memory access bridge

VERILATOR ?= verilator
TOP       ?= mam_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
